// File: design/cpu_pkg.sv
// cpu package: widths, data types, opcodes, field positions, fsm and status enums, opcode classes
`default_nettype none

package cpu_pkg;

    // ------------------------------------------------------------
    // widths and limits
    // ------------------------------------------------------------
    localparam int WORD_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int PC_W      = 8;
    localparam int REG_IDX_W = 3;
    localparam int OP_W      = 5;
    localparam int VAL3_W    = 4;
    localparam int NUM_REGS  = 8;
    localparam int PC_LAST   = 255;

    // instruction field positions (lsb of each field)
    localparam int OP_LSB   = 11;
    localparam int R1_LSB   = 8;
    localparam int R2_LSB   = 4;
    localparam int R3_LSB   = 0;
    localparam int IMM8_LSB = 0;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [PC_W-1:0]      pc_t;
    // word address plus byte select bit
    typedef logic [PC_W:0]        mem_addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [OP_W-1:0] {
        NOP  = 5'd0,  HALT = 5'd1,  LOAD = 5'd2,  STORE = 5'd3,
        LDIH = 5'd4,  ADD  = 5'd5,  ADDI = 5'd6,  SUB   = 5'd7,
        SUBI = 5'd8,  CMP  = 5'd9,  AND  = 5'd10, OR    = 5'd11,
        XOR  = 5'd12, SLL  = 5'd13, SRL  = 5'd14, SET   = 5'd15,
        JUMP = 5'd16, JMPR = 5'd17, BZ   = 5'd18, BNZ   = 5'd19,
        BN   = 5'd20, BNN  = 5'd21, BC   = 5'd22, BNC   = 5'd23
    } opcode_e;

    // seven active states per instruction plus idle
    typedef enum logic [2:0] {
        IDLE, IF, IF2, ID, EX, MEM, MEM2, WB
    } state_e;

    typedef enum logic [1:0] {
        RUNNING = 2'd0,
        HALTED  = 2'd1,
        MEM_END = 2'd2
    } run_status_e;

    // ------------------------------------------------------------
    // field extraction and opcode classes
    // ------------------------------------------------------------
    function automatic opcode_e instr_op(word_t w);
        return opcode_e'(w[OP_LSB +: OP_W]);
    endfunction

    function automatic reg_idx_t instr_r1(word_t w);
        return w[R1_LSB +: REG_IDX_W];
    endfunction

    function automatic logic writes_reg(opcode_e op);
        return op inside {LOAD, LDIH, ADD, ADDI, SUB, SUBI, AND, OR, XOR,
                          SLL, SRL, SET};
    endfunction

    function automatic logic sets_flags(opcode_e op);
        return op inside {LDIH, ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR, SLL, SRL};
    endfunction

    // gr[r1] goes to operand a
    function automatic logic uses_r1_as_a(opcode_e op);
        return op inside {LDIH, ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, BC, BNC};
    endfunction

    // gr[r2] goes to operand a
    function automatic logic uses_r2_as_a(opcode_e op);
        return op inside {LOAD, STORE, ADD, SUB, CMP, AND, OR, XOR, SLL, SRL};
    endfunction

endpackage

`default_nettype wire

// File: design/seq_control.sv
// sequencing FSM, program counter, instruction register, byte select and run status
`timescale 1ns/1ps
`default_nettype none

module seq_control (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire cpu_pkg::byte_t       i_datain,
    input  wire                       branch_taken,
    input  wire cpu_pkg::pc_t         new_pc,
    output cpu_pkg::state_e           state,
    output cpu_pkg::word_t            instr,
    output logic                      byte_sel,
    output cpu_pkg::mem_addr_t        i_addr,
    output cpu_pkg::run_status_e      run_status
);
    import cpu_pkg::*;

    state_e next_state;
    pc_t    pc;
    logic   halt_op;
    logic   at_last;

    assign halt_op = (instr_op(instr) == HALT);
    assign at_last = (pc == pc_t'(PC_LAST));

    // odd byte in the second fetch and second memory cycle
    assign byte_sel = (state == IF2) || (state == MEM2);
    assign i_addr   = {pc, byte_sel};

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (start)
                    next_state = IF;
            IF:      next_state = IF2;
            IF2:     next_state = ID;
            ID:      next_state = EX;
            EX:      next_state = MEM;
            MEM:     next_state = MEM2;
            MEM2:    next_state = WB;
            WB:
                if (halt_op || at_last)
                    next_state = IDLE;
                else
                    next_state = IF;
            default: next_state = IDLE;
        endcase
    end

    // state, pc and outcome
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            pc         <= '0;
            run_status <= HALTED;
        end
        else
        begin
            state <= next_state;
            if ((state == IDLE) && start)
            begin
                pc         <= '0;
                run_status <= RUNNING;
            end
            else if (state == WB)
            begin
                if (branch_taken)
                    pc <= new_pc;
                else if (!at_last)
                    pc <= pc + 1'b1;

                if (halt_op)
                    run_status <= HALTED;
                else if (at_last)
                    run_status <= MEM_END;
            end
        end
    end

    // instruction assembly, low byte first
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            instr <= '0;
        else if (state == IF)
            instr[BYTE_W-1:0] <= i_datain;
        else if (state == IF2)
            instr[WORD_W-1:BYTE_W] <= i_datain;
    end

    state_known_a: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(state))
        else $error("seq_control: state is unknown");

endmodule

`default_nettype wire

// File: design/reg_file.sv
// general register file with two read ports, word write and byte write paths
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::reg_idx_t rd_a_idx,
    input  wire cpu_pkg::reg_idx_t rd_b_idx,
    input  wire cpu_pkg::reg_idx_t wr_idx,
    input  wire                    wr_word,
    input  wire                    wr_lo,
    input  wire                    wr_hi,
    input  wire cpu_pkg::word_t    wr_data,
    output cpu_pkg::word_t         rd_a,
    output cpu_pkg::word_t         rd_b
);
    import cpu_pkg::*;

    word_t gr [NUM_REGS];

    assign rd_a = gr[rd_a_idx];
    assign rd_b = gr[rd_b_idx];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                gr[i] <= '0;
        end
        else if (wr_word)
            gr[wr_idx] <= wr_data;
        else
        begin
            // load halves arrive one cycle apart
            if (wr_lo)
                gr[wr_idx][BYTE_W-1:0] <= wr_data[BYTE_W-1:0];
            if (wr_hi)
                gr[wr_idx][WORD_W-1:BYTE_W] <= wr_data[WORD_W-1:BYTE_W];
        end
    end

    word_byte_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_word && (wr_lo || wr_hi)))
        else $error("reg_file: word write collides with byte write");

endmodule

`default_nettype wire

// File: design/operand_decode.sv
// operand decode: register index select and operand a, operand b, store data latches
`timescale 1ns/1ps
`default_nettype none

module operand_decode (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::state_e   state,
    input  wire cpu_pkg::word_t    instr,
    input  wire cpu_pkg::word_t    rd_a,
    input  wire cpu_pkg::word_t    rd_b,
    output cpu_pkg::reg_idx_t      rd_a_idx,
    output cpu_pkg::reg_idx_t      rd_b_idx,
    output cpu_pkg::word_t         op_a,
    output cpu_pkg::word_t         op_b,
    output cpu_pkg::word_t         store_data
);
    import cpu_pkg::*;

    opcode_e  op;
    reg_idx_t r2;
    reg_idx_t r3;
    byte_t    imm8;
    logic     b_from_reg;
    word_t    a_next;
    word_t    b_next;

    assign op   = instr_op(instr);
    assign r2   = instr[R2_LSB +: REG_IDX_W];
    assign r3   = instr[R3_LSB +: REG_IDX_W];
    assign imm8 = instr[IMM8_LSB +: BYTE_W];

    // port b reads r3 for register ops, otherwise r1 for store data
    assign rd_a_idx = uses_r1_as_a(op) ? instr_r1(instr) : r2;
    assign rd_b_idx = b_from_reg ? r3 : instr_r1(instr);

    // jump and set see zero on operand a
    assign a_next = (uses_r1_as_a(op) || uses_r2_as_a(op)) ? rd_a : '0;

    // ------------------------------------------------------------
    // operand b source
    // ------------------------------------------------------------
    always_comb
    begin
        b_from_reg = 1'b0;
        case (op)
            LOAD, STORE, SLL, SRL:
                b_next = word_t'(instr[VAL3_W-1:0]);
            ADDI, SUBI, SET, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                b_next = word_t'(imm8);
            LDIH:
                b_next = {imm8, byte_t'(0)};
            ADD, SUB, CMP, AND, OR, XOR:
            begin
                b_from_reg = 1'b1;
                b_next     = rd_b;
            end
            default:
                b_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            op_a       <= '0;
            op_b       <= '0;
            store_data <= '0;
        end
        else if (state == ID)
        begin
            op_a <= a_next;
            op_b <= b_next;
            if (op == STORE)
                store_data <= rd_b;
        end
    end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
// ALU, zero/negative/carry flags, result register and branch decision
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::state_e   state,
    input  wire cpu_pkg::word_t    instr,
    input  wire cpu_pkg::word_t    op_a,
    input  wire cpu_pkg::word_t    op_b,
    output cpu_pkg::word_t         result,
    output logic                   branch_taken,
    output cpu_pkg::pc_t           new_pc
);
    import cpu_pkg::*;

    opcode_e         op;
    logic [WORD_W:0] sum;
    logic [WORD_W:0] diff;
    word_t           alu_out;
    logic            alu_carry;
    logic            zf;
    logic            nf;
    logic            cf;

    assign op = instr_op(instr);

    // bit 16 is the carry out, or the borrow for subtraction
    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = {1'b0, op_a} - {1'b0, op_b};

    // ------------------------------------------------------------
    // combinational ALU
    // ------------------------------------------------------------
    always_comb
    begin
        alu_carry = cf;
        case (op)
            ADD, ADDI, LDIH: {alu_carry, alu_out} = sum;
            SUB, SUBI, CMP:  {alu_carry, alu_out} = diff;
            AND:
            begin
                alu_out   = op_a & op_b;
                alu_carry = 1'b0;
            end
            OR:
            begin
                alu_out   = op_a | op_b;
                alu_carry = 1'b0;
            end
            XOR:
            begin
                alu_out   = op_a ^ op_b;
                alu_carry = 1'b0;
            end
            SLL:        alu_out = op_a << op_b[VAL3_W-1:0];
            SRL:        alu_out = op_a >> op_b[VAL3_W-1:0];
            SET, JUMP:  alu_out = op_b;
            // address and branch target math
            default:    alu_out = sum[WORD_W-1:0];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result <= '0;
            zf     <= 1'b0;
            nf     <= 1'b0;
            cf     <= 1'b0;
        end
        else if (state == EX)
        begin
            result <= alu_out;
            if (sets_flags(op))
            begin
                cf <= alu_carry;
                zf <= (alu_out == '0);
                nf <= alu_out[WORD_W-1];
            end
        end
    end

    // ------------------------------------------------------------
    // branch decision on flags of the last flag-setting op
    // ------------------------------------------------------------
    always_comb
    begin
        case (op)
            JUMP, JMPR: branch_taken = 1'b1;
            BZ:         branch_taken = zf;
            BNZ:        branch_taken = !zf;
            BN:         branch_taken = nf;
            BNN:        branch_taken = !nf;
            BC:         branch_taken = cf;
            BNC:        branch_taken = !cf;
            default:    branch_taken = 1'b0;
        endcase
    end

    assign new_pc = result[PC_W-1:0];

endmodule

`default_nettype wire

// File: design/result_writeback.sv
// byte-serial data memory port, load byte routing and register write control
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
    input  wire cpu_pkg::state_e   state,
    input  wire cpu_pkg::word_t    instr,
    input  wire                    byte_sel,
    input  wire cpu_pkg::word_t    result,
    input  wire cpu_pkg::word_t    store_data,
    input  wire cpu_pkg::byte_t    d_datain,
    output cpu_pkg::mem_addr_t     d_addr,
    output logic                   d_we,
    output cpu_pkg::byte_t         d_dataout,
    output cpu_pkg::reg_idx_t      wr_idx,
    output logic                   wr_word,
    output logic                   wr_lo,
    output logic                   wr_hi,
    output cpu_pkg::word_t         wr_data
);
    import cpu_pkg::*;

    opcode_e op;
    logic    mem_phase;

    assign op        = instr_op(instr);
    assign mem_phase = (state == MEM) || (state == MEM2);

    // ------------------------------------------------------------
    // data memory side
    // ------------------------------------------------------------
    // word address from the ALU with the byte select as lsb
    assign d_addr    = {result[PC_W-1:0], byte_sel};
    assign d_we      = mem_phase && (op == STORE);
    assign d_dataout = byte_sel ? store_data[WORD_W-1:BYTE_W] : store_data[BYTE_W-1:0];

    // ------------------------------------------------------------
    // register write side
    // ------------------------------------------------------------
    assign wr_idx  = instr_r1(instr);
    assign wr_lo   = (state == MEM) && (op == LOAD);
    assign wr_hi   = (state == MEM2) && (op == LOAD);
    assign wr_word = (state == WB) && writes_reg(op) && (op != LOAD);

    // load byte on both halves and the byte enable picks one
    assign wr_data = wr_word ? result : {d_datain, d_datain};

endmodule

`default_nettype wire

// File: design/serial_cpu_top.sv
// serial CPU top level connecting sequencer, register file, decode, ALU and writeback
`timescale 1ns/1ps
`default_nettype none

module serial_cpu_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire cpu_pkg::byte_t       i_datain,
    input  wire cpu_pkg::byte_t       d_datain,
    output cpu_pkg::mem_addr_t        i_addr,
    output cpu_pkg::mem_addr_t        d_addr,
    output logic                      d_we,
    output cpu_pkg::byte_t            d_dataout,
    output cpu_pkg::run_status_e      run_status
);
    import cpu_pkg::*;

    state_e   state;
    word_t    instr;
    logic     byte_sel;
    logic     branch_taken;
    pc_t      new_pc;
    reg_idx_t rd_a_idx;
    reg_idx_t rd_b_idx;
    word_t    rd_a;
    word_t    rd_b;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;
    word_t    result;
    reg_idx_t wr_idx;
    logic     wr_word;
    logic     wr_lo;
    logic     wr_hi;
    word_t    wr_data;

    seq_control seq_control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .i_datain     (i_datain),
        .branch_taken (branch_taken),
        .new_pc       (new_pc),
        .state        (state),
        .instr        (instr),
        .byte_sel     (byte_sel),
        .i_addr       (i_addr),
        .run_status   (run_status)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .wr_idx   (wr_idx),
        .wr_word  (wr_word),
        .wr_lo    (wr_lo),
        .wr_hi    (wr_hi),
        .wr_data  (wr_data),
        .rd_a     (rd_a),
        .rd_b     (rd_b)
    );

    operand_decode operand_decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .instr      (instr),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_data (store_data)
    );

    alu_execute alu_execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .instr        (instr),
        .op_a         (op_a),
        .op_b         (op_b),
        .result       (result),
        .branch_taken (branch_taken),
        .new_pc       (new_pc)
    );

    result_writeback result_writeback_i (
        .state      (state),
        .instr      (instr),
        .byte_sel   (byte_sel),
        .result     (result),
        .store_data (store_data),
        .d_datain   (d_datain),
        .d_addr     (d_addr),
        .d_we       (d_we),
        .d_dataout  (d_dataout),
        .wr_idx     (wr_idx),
        .wr_word    (wr_word),
        .wr_lo      (wr_lo),
        .wr_hi      (wr_hi),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

// File: dv/byte_mem_model.sv
// instruction and data byte memories with a loader port and a store recorder
`timescale 1ns/1ps
`default_nettype none

module byte_mem_model (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     ld_en,
    input  wire                     ld_instr,
    input  wire cpu_pkg::mem_addr_t ld_addr,
    input  wire cpu_pkg::byte_t     ld_data,
    input  wire                     clr_rec,
    input  wire cpu_pkg::mem_addr_t i_addr,
    output cpu_pkg::byte_t          i_datain,
    input  wire cpu_pkg::mem_addr_t d_addr,
    input  wire                     d_we,
    input  wire cpu_pkg::byte_t     d_dataout,
    output cpu_pkg::byte_t          d_datain,
    output logic [7:0]              store_count,
    output cpu_pkg::pc_t            store_addr,
    output cpu_pkg::word_t          store_value
);
    import cpu_pkg::*;

    localparam int MEM_BYTES = 512;

    byte_t i_mem [MEM_BYTES];
    byte_t d_mem [MEM_BYTES];
    byte_t store_lo;

    // both memories answer in the same cycle
    assign i_datain = i_mem[i_addr];
    assign d_datain = d_mem[d_addr];

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int a = 0; a < MEM_BYTES; a++)
            begin
                i_mem[a] <= '0;
                d_mem[a] <= '0;
            end
            store_lo    <= '0;
            store_count <= '0;
            store_addr  <= '0;
            store_value <= '0;
        end
        else
        begin
            if (ld_en && ld_instr)
                i_mem[ld_addr] <= ld_data;
            else if (ld_en)
                d_mem[ld_addr] <= ld_data;

            if (d_we)
                d_mem[d_addr] <= d_dataout;

            // ----------------------------------------------------------
            // store recorder, low byte first then high byte
            // ----------------------------------------------------------
            if (clr_rec)
                store_count <= '0;
            else if (d_we && !d_addr[0])
                store_lo <= d_dataout;
            else if (d_we)
            begin
                store_value <= {d_dataout, store_lo};
                store_addr  <= d_addr[PC_W:1];
                store_count <= store_count + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/serial_cpu_tb.sv
// serial CPU testbench with clock, reset, program table, run loop, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module serial_cpu_tb;
    import cpu_pkg::*;

    localparam int    NUM_ROWS  = 11;
    localparam int    PROG_LEN  = 8;
    localparam int    RUN_LIMIT = NUM_ROWS * PROG_LEN * 7 + 100;
    localparam word_t NOP_W     = 16'h0000;
    localparam word_t HALT_W    = 16'h0800;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        ld_en;
    logic        ld_instr;
    mem_addr_t   ld_addr;
    byte_t       ld_data;
    logic        clr_rec;
    byte_t       i_datain;
    byte_t       d_datain;
    mem_addr_t   i_addr;
    mem_addr_t   d_addr;
    logic        d_we;
    byte_t       d_dataout;
    run_status_e run_status;
    logic [7:0]  store_count;
    pc_t         store_addr;
    word_t       store_value;

    // program table
    string       name         [NUM_ROWS];
    word_t       prog         [NUM_ROWS][PROG_LEN];
    int          n_instr      [NUM_ROWS];
    pc_t         exp_addr     [NUM_ROWS];
    word_t       exp_value    [NUM_ROWS];
    run_status_e exp_status   [NUM_ROWS];
    logic        preset_en    [NUM_ROWS];
    pc_t         preset_addr  [NUM_ROWS];
    word_t       preset_value [NUM_ROWS];

    int   num_rows   = 0;
    int   errors     = 0;
    int   rows_ok    = 0;
    int   run_cycles = 0;
    int   seed       = 32'h5df7;
    logic in_run     = 1'b0;

    serial_cpu_top serial_cpu_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .i_datain   (i_datain),
        .d_datain   (d_datain),
        .i_addr     (i_addr),
        .d_addr     (d_addr),
        .d_we       (d_we),
        .d_dataout  (d_dataout),
        .run_status (run_status)
    );

    byte_mem_model byte_mem_model_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ld_en       (ld_en),
        .ld_instr    (ld_instr),
        .ld_addr     (ld_addr),
        .ld_data     (ld_data),
        .clr_rec     (clr_rec),
        .i_addr      (i_addr),
        .i_datain    (i_datain),
        .d_addr      (d_addr),
        .d_we        (d_we),
        .d_dataout   (d_dataout),
        .d_datain    (d_datain),
        .store_count (store_count),
        .store_addr  (store_addr),
        .store_value (store_value)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // watchdog over the cycles spent inside runs
    always @(posedge clk)
    begin
        if (in_run)
            run_cycles <= run_cycles + 1;
        if (run_cycles >= RUN_LIMIT)
        begin
            $display("timeout: runs took more than %0d cycles", RUN_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // instruction encoding
    // ------------------------------------------------------------
    function automatic word_t encode_reg(opcode_e op, int r1, int r2, int r3);
        return {op, r1[2:0], 1'b0, r2[2:0], 1'b0, r3[2:0]};
    endfunction

    function automatic word_t encode_imm(opcode_e op, int r1, byte_t imm8);
        return {op, r1[2:0], imm8};
    endfunction

    function automatic word_t encode_val(opcode_e op, int r1, int r2, int val3);
        return {op, r1[2:0], 1'b0, r2[2:0], val3[3:0]};
    endfunction

    task automatic add_row(
        input string       row_name,
        input word_t       w0,
        input word_t       w1,
        input word_t       w2,
        input word_t       w3,
        input word_t       w4,
        input word_t       w5,
        input word_t       w6,
        input word_t       w7,
        input int          n,
        input pc_t         addr,
        input word_t       value,
        input run_status_e status
    );
        name[num_rows]       = row_name;
        prog[num_rows][0]    = w0;
        prog[num_rows][1]    = w1;
        prog[num_rows][2]    = w2;
        prog[num_rows][3]    = w3;
        prog[num_rows][4]    = w4;
        prog[num_rows][5]    = w5;
        prog[num_rows][6]    = w6;
        prog[num_rows][7]    = w7;
        n_instr[num_rows]    = n;
        exp_addr[num_rows]   = addr;
        exp_value[num_rows]  = value;
        exp_status[num_rows] = status;
        preset_en[num_rows]  = 1'b0;
        num_rows++;
    endtask

    task automatic build_table();
        int    rnd;
        word_t ld_word;

        add_row("set_add_sub",
            encode_imm(SET, 1, 8'h9c), encode_imm(SET, 2, 8'h47), encode_reg(ADD, 3, 1, 2),
            encode_reg(SUB, 4, 2, 3), NOP_W, encode_val(STORE, 4, 0, 5), HALT_W, NOP_W,
            7, 8'd5, 16'h0047 - (16'h009c + 16'h0047), HALTED);
        add_row("ldih_addi_subi",
            encode_imm(LDIH, 7, 8'ha5), encode_imm(ADDI, 7, 8'h3c), encode_imm(SUBI, 7, 8'h0f),
            encode_val(STORE, 7, 0, 1), HALT_W, NOP_W, NOP_W, NOP_W,
            5, 8'd1, 16'ha500 + 16'h003c - 16'h000f, HALTED);
        add_row("and_or_xor",
            encode_imm(SET, 1, 8'hf0), encode_imm(LDIH, 1, 8'h5a), encode_imm(SET, 2, 8'h3c),
            encode_reg(AND, 3, 1, 2), encode_reg(OR, 4, 1, 2), encode_reg(XOR, 5, 3, 4),
            encode_val(STORE, 5, 0, 2), HALT_W,
            8, 8'd2, (16'h5af0 & 16'h003c) ^ (16'h5af0 | 16'h003c), HALTED);
        add_row("sll_srl",
            encode_imm(SET, 1, 8'hb7), encode_val(SLL, 2, 1, 9), encode_val(SRL, 3, 2, 3),
            encode_val(STORE, 3, 0, 3), HALT_W, NOP_W, NOP_W, NOP_W,
            5, 8'd3, word_t'(16'h00b7 << 9) >> 3, HALTED);

        // loaded word comes from the seeded preset
        rnd     = $random(seed);
        ld_word = rnd[15:0];
        add_row("load_store",
            encode_imm(SET, 2, 8'h40), encode_val(LOAD, 1, 2, 6), encode_imm(ADDI, 1, 8'h11),
            encode_val(STORE, 1, 2, 7), HALT_W, NOP_W, NOP_W, NOP_W,
            5, 8'h47, ld_word + 16'h0011, HALTED);
        preset_en[num_rows-1]    = 1'b1;
        preset_addr[num_rows-1]  = 8'h46;
        preset_value[num_rows-1] = ld_word;

        // 8'hee marks the fall-through path in the branch rows
        add_row("cmp_bz_taken",
            encode_imm(SET, 1, 8'h33), encode_imm(SET, 2, 8'h33), encode_reg(CMP, 0, 1, 2),
            encode_imm(BZ, 0, 8'd5), encode_imm(SET, 1, 8'hee), encode_val(STORE, 1, 0, 8),
            HALT_W, NOP_W,
            6, 8'd8, 16'h0033, HALTED);
        add_row("cmp_bnz_not_taken",
            encode_imm(SET, 1, 8'h33), encode_imm(SET, 2, 8'h33), encode_reg(CMP, 0, 1, 2),
            encode_imm(BNZ, 0, 8'd5), encode_imm(SET, 1, 8'hee), encode_val(STORE, 1, 0, 8),
            HALT_W, NOP_W,
            7, 8'd8, 16'h00ee, HALTED);
        add_row("borrow_bc_taken",
            encode_imm(SET, 1, 8'h10), encode_imm(SET, 2, 8'h20), encode_reg(SUB, 3, 1, 2),
            encode_imm(BC, 0, 8'd5), encode_imm(SET, 3, 8'hee), encode_val(STORE, 3, 0, 9),
            HALT_W, NOP_W,
            6, 8'd9, 16'h0010 - 16'h0020, HALTED);
        add_row("borrow_bnc_not_taken",
            encode_imm(SET, 1, 8'h10), encode_imm(SET, 2, 8'h20), encode_reg(SUB, 3, 1, 2),
            encode_imm(BNC, 0, 8'd5), encode_imm(SET, 3, 8'hee), encode_val(STORE, 3, 0, 9),
            HALT_W, NOP_W,
            7, 8'd9, 16'h00ee, HALTED);
        add_row("jump_jmpr",
            encode_imm(SET, 1, 8'h01), encode_imm(JUMP, 0, 8'd4), encode_val(STORE, 2, 0, 10),
            HALT_W, encode_imm(SET, 2, 8'h5c), encode_imm(JMPR, 1, 8'd1),
            encode_imm(SET, 2, 8'hee), HALT_W,
            6, 8'd10, 16'h005c, HALTED);
        // word 255 is a NOP, so the run ends on the last pc
        add_row("jump_mem_end",
            encode_imm(SET, 1, 8'h6b), encode_val(STORE, 1, 0, 11), encode_imm(JUMP, 0, 8'hff),
            HALT_W, NOP_W, NOP_W, NOP_W, NOP_W,
            4, 8'd11, 16'h006b, MEM_END);
    endtask

    // ------------------------------------------------------------
    // memory loading, checks and the run loop
    // ------------------------------------------------------------
    task automatic load_byte(input logic to_instr, input mem_addr_t addr, input byte_t data);
        ld_en    <= 1'b1;
        ld_instr <= to_instr;
        ld_addr  <= addr;
        ld_data  <= data;
        @(posedge clk);
    endtask

    task automatic report_mismatch(input string where, input string sig,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %s: %s got 0x%0h expected 0x%0h", where, sig, got, exp);
        errors++;
    endtask

    task automatic run_row(input int r);
        int cycles;
        int errors_before;

        errors_before = errors;
        @(posedge clk);
        for (int k = 0; k < PROG_LEN; k++)
        begin
            load_byte(1'b1, {pc_t'(k), 1'b0}, prog[r][k][7:0]);
            load_byte(1'b1, {pc_t'(k), 1'b1}, prog[r][k][15:8]);
        end
        if (preset_en[r])
        begin
            load_byte(1'b0, {preset_addr[r], 1'b0}, preset_value[r][7:0]);
            load_byte(1'b0, {preset_addr[r], 1'b1}, preset_value[r][15:8]);
        end
        ld_en   <= 1'b0;
        clr_rec <= 1'b1;
        @(posedge clk);
        clr_rec <= 1'b0;
        start   <= 1'b1;
        in_run  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (run_status == RUNNING)
        begin
            cycles++;
            @(negedge clk);
        end
        in_run <= 1'b0;

        if (cycles != 7 * n_instr[r])
            report_mismatch(name[r], "cycles", 32'(cycles), 32'(7 * n_instr[r]));
        if (run_status !== exp_status[r])
            report_mismatch(name[r], "run_status", 32'(run_status), 32'(exp_status[r]));
        if (d_we !== 1'b0)
            report_mismatch(name[r], "d_we", 32'(d_we), 32'd0);
        if (store_count !== 8'd1)
            report_mismatch(name[r], "store_count", 32'(store_count), 32'd1);
        if (store_count != 8'd0)
        begin
            if (store_addr !== exp_addr[r])
                report_mismatch(name[r], "store_addr", 32'(store_addr), 32'(exp_addr[r]));
            if (store_value !== exp_value[r])
                report_mismatch(name[r], "store_value", 32'(store_value), 32'(exp_value[r]));
        end

        if (errors == errors_before)
        begin
            rows_ok++;
            $display("[row %0d] %s: ok, %0d cycles", r, name[r], cycles);
        end
        else
            $display("[row %0d] %s: FAILED", r, name[r]);
    endtask

    initial
    begin
        rst_n    = 1'b0;
        start    = 1'b0;
        ld_en    = 1'b0;
        ld_instr = 1'b0;
        ld_addr  = '0;
        ld_data  = '0;
        clr_rec  = 1'b0;
        build_table();

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (run_status !== HALTED)
            report_mismatch("reset", "run_status", 32'(run_status), 32'(HALTED));
        if (d_we !== 1'b0)
            report_mismatch("reset", "d_we", 32'(d_we), 32'd0);

        for (int r = 0; r < num_rows; r++)
            run_row(r);

        @(posedge clk);
        $display("%0d of %0d rows ok, %0d errors", rows_ok, num_rows, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
design/cpu_pkg.sv
design/seq_control.sv
design/reg_file.sv
design/operand_decode.sv
design/alu_execute.sv
design/result_writeback.sv
design/serial_cpu_top.sv
dv/byte_mem_model.sv
dv/serial_cpu_tb.sv

// File: Makefile
# Verilator build and run of the serial CPU testbench

VERILATOR ?= verilator
TOP       ?= serial_cpu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
